//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_cpu_core
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- hw/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
	input  wire              clk,
	input  wire              rst,
	input  wire              i_instr_valid,
	input  wire  [31:0]      i_instr,
	output cpu_pkg::retire_t o_retire
);

	logic [3:0]            ra_idx;
	logic [3:0]            rb_idx;
	logic [31:0]           ra_val;
	logic [31:0]           rb_val;
	logic                  rf_wr_en;
	logic [3:0]            rf_wr_idx;
	logic [31:0]           rf_wr_val;
	cpu_pkg::exec_ctrl_t   ctrl;
	cpu_pkg::exec_result_t result;

	reg_file u_reg_file (
		.clk      (clk),
		.rst      (rst),
		.i_ra_idx (ra_idx),
		.i_rb_idx (rb_idx),
		.o_ra_val (ra_val),
		.o_rb_val (rb_val),
		.i_wr_en  (rf_wr_en),
		.i_wr_idx (rf_wr_idx),
		.i_wr_val (rf_wr_val)
	);

	instr_decode u_decode (
		.clk           (clk),
		.rst           (rst),
		.i_instr_valid (i_instr_valid),
		.i_instr       (i_instr),
		.o_ra_idx      (ra_idx),
		.o_rb_idx      (rb_idx),
		.i_ra_val      (ra_val),
		.i_rb_val      (rb_val),
		.o_ctrl        (ctrl)
	);

	exec_stage u_exec (
		.clk      (clk),
		.rst      (rst),
		.i_ctrl   (ctrl),
		.o_result (result)
	);

	mem_writeback u_writeback (
		.clk         (clk),
		.rst         (rst),
		.i_result    (result),
		.o_rf_wr_en  (rf_wr_en),
		.o_rf_wr_idx (rf_wr_idx),
		.o_rf_wr_val (rf_wr_val),
		.o_retire    (o_retire)
	);

endmodule

`default_nettype wire

//--- hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// instruction word field positions
	localparam int CLASS_LSB   = 30;
	localparam int OPC_LSB     = 25;
	localparam int OPC_W       = 5;
	localparam int RD_LSB      = 21;
	localparam int RA_LSB      = 17;
	localparam int RB_LSB      = 13;
	localparam int USE_IMM_BIT = 12;
	localparam int IMM_MSB     = 11;
	localparam int REG_IDX_W   = 4;
	localparam int NUM_REGS    = 16;

	localparam logic [1:0] CLASS_ALU    = 2'b00;
	localparam logic [1:0] CLASS_BRANCH = 2'b01;
	localparam logic [1:0] CLASS_MEM    = 2'b10;
	localparam logic [1:0] CLASS_CR     = 2'b11;

	localparam logic [4:0] ALU_OPC_ADD   = 5'h00;
	localparam logic [4:0] ALU_OPC_ADDC  = 5'h01;
	localparam logic [4:0] ALU_OPC_SUB   = 5'h02;
	localparam logic [4:0] ALU_OPC_SUBC  = 5'h03;
	localparam logic [4:0] ALU_OPC_LSL   = 5'h04;
	localparam logic [4:0] ALU_OPC_LSR   = 5'h05;
	localparam logic [4:0] ALU_OPC_AND   = 5'h06;
	localparam logic [4:0] ALU_OPC_XOR   = 5'h07;
	localparam logic [4:0] ALU_OPC_BIC   = 5'h08;
	localparam logic [4:0] ALU_OPC_BST   = 5'h09;
	localparam logic [4:0] ALU_OPC_OR    = 5'h0a;
	localparam logic [4:0] ALU_OPC_COPYB = 5'h0b;
	localparam logic [4:0] ALU_OPC_CMP   = 5'h0c;
	localparam logic [4:0] ALU_OPC_MOVHI = 5'h0d;
	localparam logic [4:0] ALU_OPC_ASR   = 5'h0e;
	localparam logic [4:0] ALU_OPC_MUL   = 5'h0f;

	localparam logic [4:0] MEM_OPC_LOAD  = 5'h00;
	localparam logic [4:0] MEM_OPC_STORE = 5'h04;

	localparam logic [4:0] CR_OPC_GCR = 5'h00;
	localparam logic [4:0] CR_OPC_SCR = 5'h01;

	localparam logic [2:0] CR_VBAR = 3'd0; // vector base
	localparam logic [2:0] CR_PSR  = 3'd1; // {N, O, C, Z} in bits 3:0

	// branch condition codes live in opc[3:0]
	localparam logic [3:0] BRANCH_CC_NE   = 4'b0001;
	localparam logic [3:0] BRANCH_CC_EQ   = 4'b0010;
	localparam logic [3:0] BRANCH_CC_GT   = 4'b0011;
	localparam logic [3:0] BRANCH_CC_LT   = 4'b0100;
	localparam logic [3:0] BRANCH_CC_GTS  = 4'b0101;
	localparam logic [3:0] BRANCH_CC_LTS  = 4'b0110;
	localparam logic [3:0] BRANCH_CC_B    = 4'b0111;
	localparam logic [3:0] BRANCH_CC_GTE  = 4'b1000;
	localparam logic [3:0] BRANCH_CC_GTES = 4'b1001;
	localparam logic [3:0] BRANCH_CC_LTE  = 4'b1010;
	localparam logic [3:0] BRANCH_CC_LTES = 4'b1011;

	localparam int DMEM_WORDS = 64;
	localparam int DMEM_AW    = 6; // word index comes from address bits 7:2

	typedef struct packed {
		logic                 valid;
		logic [1:0]           cls;
		logic [OPC_W-1:0]     opc;
		logic [REG_IDX_W-1:0] rd;
		logic                 write_rd;
		logic [31:0]          ra_val;
		logic [31:0]          rb_val;
		logic [31:0]          imm;
		logic                 use_imm;
		logic                 update_flags;
		logic                 update_carry;
	} exec_ctrl_t;

	typedef struct packed {
		logic                 valid;
		logic                 write_rd;
		logic [REG_IDX_W-1:0] rd;
		logic [31:0]          value;
		logic                 mem_load;
		logic                 mem_store;
		logic [31:0]          addr;
		logic [31:0]          store_data;
		logic                 branch;
		logic                 branch_taken;
	} exec_result_t;

	typedef struct packed {
		logic                 valid;
		logic                 write_rd;
		logic [REG_IDX_W-1:0] rd;
		logic [31:0]          data; // written value, branch target for branches
		logic                 is_branch;
		logic                 taken;
	} retire_t;

endpackage

`default_nettype wire

//--- hw/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
	input  wire                   clk,
	input  wire                   rst,
	input  cpu_pkg::exec_ctrl_t   i_ctrl,
	output cpu_pkg::exec_result_t o_result
);

	logic [31:0] op1;
	logic [31:0] op2;
	logic [31:0] alu_q;
	logic [31:0] addr;
	logic [31:0] cr_rd_val;
	logic        alu_c;
	logic        alu_z;
	logic        alu_n;
	logic        alu_o;
	logic        z_flag;
	logic        c_flag;
	logic        n_flag;
	logic        o_flag;
	logic [25:0] vector_addr;
	logic        cond_met;
	logic [2:0]  cr_sel;
	logic        write_cr;
	cpu_pkg::exec_result_t result_d;

	assign op1      = i_ctrl.ra_val;
	assign op2      = i_ctrl.use_imm ? i_ctrl.imm : i_ctrl.rb_val;
	assign alu_z    = op1 == op2;
	assign addr     = i_ctrl.ra_val + i_ctrl.imm; // load/store address and branch target
	assign cr_sel   = i_ctrl.imm[2:0];
	assign write_cr = i_ctrl.valid && i_ctrl.cls == cpu_pkg::CLASS_CR &&
	                  i_ctrl.opc == cpu_pkg::CR_OPC_SCR;

	always_comb begin
		alu_c = 1'b0;
		alu_n = 1'b0;
		alu_o = 1'b0;
		case (i_ctrl.opc)
		cpu_pkg::ALU_OPC_ADD:   {alu_c, alu_q} = op1 + op2;
		cpu_pkg::ALU_OPC_ADDC:  {alu_c, alu_q} = op1 + op2 + {31'b0, c_flag};
		cpu_pkg::ALU_OPC_SUB:   {alu_c, alu_q} = op1 - op2;
		cpu_pkg::ALU_OPC_SUBC:  {alu_c, alu_q} = op1 - op2 - {31'b0, c_flag};
		cpu_pkg::ALU_OPC_MUL:   alu_q = op1 * op2;
		cpu_pkg::ALU_OPC_LSL:   alu_q = op1 << op2[4:0];
		cpu_pkg::ALU_OPC_LSR:   alu_q = op1 >> op2[4:0];
		cpu_pkg::ALU_OPC_AND:   alu_q = op1 & op2;
		cpu_pkg::ALU_OPC_XOR:   alu_q = op1 ^ op2;
		cpu_pkg::ALU_OPC_BIC:   alu_q = op1 & ~(32'b1 << op2[4:0]);
		cpu_pkg::ALU_OPC_BST:   alu_q = op1 | (32'b1 << op2[4:0]);
		cpu_pkg::ALU_OPC_OR:    alu_q = op1 | op2;
		cpu_pkg::ALU_OPC_COPYB: alu_q = op2;
		cpu_pkg::ALU_OPC_CMP: begin
			{alu_c, alu_q} = op1 - op2;
			alu_c = ~alu_c; // carry set means no borrow
			alu_o = (op1[31] ^ op2[31]) && alu_q[31] == op2[31];
			alu_n = alu_q[31];
		end
		cpu_pkg::ALU_OPC_MOVHI: alu_q = op1 | {16'b0, op2[15:0]};
		cpu_pkg::ALU_OPC_ASR:   alu_q = $signed(op1) >>> op2[4:0];
		default:                alu_q = 32'b0;
		endcase
	end

	always_comb begin
		case (cr_sel)
		cpu_pkg::CR_VBAR: cr_rd_val = {vector_addr, 6'b0};
		cpu_pkg::CR_PSR:  cr_rd_val = {28'b0, n_flag, o_flag, c_flag, z_flag};
		default:          cr_rd_val = 32'b0;
		endcase
	end

	always_comb begin
		case (i_ctrl.opc[3:0])
		cpu_pkg::BRANCH_CC_NE:   cond_met = !z_flag;
		cpu_pkg::BRANCH_CC_EQ:   cond_met = z_flag;
		cpu_pkg::BRANCH_CC_GT:   cond_met = c_flag && !z_flag;
		cpu_pkg::BRANCH_CC_LT:   cond_met = !c_flag;
		cpu_pkg::BRANCH_CC_GTS:  cond_met = !z_flag && (n_flag == o_flag);
		cpu_pkg::BRANCH_CC_LTS:  cond_met = n_flag != o_flag;
		cpu_pkg::BRANCH_CC_B:    cond_met = 1'b1;
		cpu_pkg::BRANCH_CC_GTE:  cond_met = c_flag;
		cpu_pkg::BRANCH_CC_GTES: cond_met = n_flag == o_flag;
		cpu_pkg::BRANCH_CC_LTE:  cond_met = !c_flag || z_flag;
		cpu_pkg::BRANCH_CC_LTES: cond_met = (n_flag != o_flag) || z_flag;
		default:                 cond_met = 1'b0;
		endcase
	end

	always_comb begin
		result_d.valid        = i_ctrl.valid;
		result_d.write_rd     = i_ctrl.write_rd;
		result_d.rd           = i_ctrl.rd;
		result_d.addr         = addr;
		result_d.store_data   = i_ctrl.rb_val;
		result_d.mem_load     = i_ctrl.valid && i_ctrl.cls == cpu_pkg::CLASS_MEM &&
		                        i_ctrl.opc == cpu_pkg::MEM_OPC_LOAD;
		result_d.mem_store    = i_ctrl.valid && i_ctrl.cls == cpu_pkg::CLASS_MEM &&
		                        i_ctrl.opc == cpu_pkg::MEM_OPC_STORE;
		result_d.branch       = i_ctrl.valid && i_ctrl.cls == cpu_pkg::CLASS_BRANCH;
		result_d.branch_taken = result_d.branch && cond_met;

		// stores and scr report the word they wrote, loads are filled in at writeback
		case (i_ctrl.cls)
		cpu_pkg::CLASS_ALU:    result_d.value = alu_q;
		cpu_pkg::CLASS_BRANCH: result_d.value = addr;
		cpu_pkg::CLASS_MEM:    result_d.value = result_d.mem_store ? i_ctrl.rb_val : 32'b0;
		default: begin
			if (i_ctrl.opc == cpu_pkg::CR_OPC_GCR)
				result_d.value = cr_rd_val;
			else if (i_ctrl.opc == cpu_pkg::CR_OPC_SCR)
				result_d.value = i_ctrl.ra_val;
			else
				result_d.value = 32'b0;
		end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			z_flag      <= 1'b0;
			c_flag      <= 1'b0;
			n_flag      <= 1'b0;
			o_flag      <= 1'b0;
			vector_addr <= 26'b0;
		end else if (i_ctrl.valid) begin
			if (i_ctrl.update_flags) begin
				z_flag <= alu_z;
				n_flag <= alu_n;
				o_flag <= alu_o;
			end
			if (i_ctrl.update_carry)
				c_flag <= alu_c;

			// a psr write comes last so it wins over any flag update
			if (write_cr && cr_sel == cpu_pkg::CR_PSR)
				{n_flag, o_flag, c_flag, z_flag} <= i_ctrl.ra_val[3:0];
			if (write_cr && cr_sel == cpu_pkg::CR_VBAR)
				vector_addr <= i_ctrl.ra_val[31:6];
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			o_result <= '0;
		else
			o_result <= result_d;
	end

endmodule

`default_nettype wire

//--- hw/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 i_instr_valid,
	input  wire  [31:0]         i_instr,
	output logic [3:0]          o_ra_idx,
	output logic [3:0]          o_rb_idx,
	input  wire  [31:0]         i_ra_val,
	input  wire  [31:0]         i_rb_val,
	output cpu_pkg::exec_ctrl_t o_ctrl
);

	logic [1:0]          cls;
	logic [4:0]          opc;
	logic                write_rd;
	logic                is_alu;
	cpu_pkg::exec_ctrl_t ctrl_d;

	assign cls      = i_instr[cpu_pkg::CLASS_LSB +: 2];
	assign opc      = i_instr[cpu_pkg::OPC_LSB +: cpu_pkg::OPC_W];
	assign o_ra_idx = i_instr[cpu_pkg::RA_LSB +: cpu_pkg::REG_IDX_W];
	assign o_rb_idx = i_instr[cpu_pkg::RB_LSB +: cpu_pkg::REG_IDX_W];
	assign is_alu   = cls == cpu_pkg::CLASS_ALU;

	always_comb begin
		case (cls)
		cpu_pkg::CLASS_ALU: write_rd = opc != cpu_pkg::ALU_OPC_CMP; // cmp only sets flags
		cpu_pkg::CLASS_MEM: write_rd = opc == cpu_pkg::MEM_OPC_LOAD;
		cpu_pkg::CLASS_CR:  write_rd = opc == cpu_pkg::CR_OPC_GCR;
		default:            write_rd = 1'b0;
		endcase
	end

	always_comb begin
		ctrl_d.valid    = i_instr_valid;
		ctrl_d.cls      = cls;
		ctrl_d.opc      = opc;
		ctrl_d.rd       = i_instr[cpu_pkg::RD_LSB +: cpu_pkg::REG_IDX_W];
		ctrl_d.write_rd = write_rd;
		ctrl_d.ra_val   = i_ra_val;
		ctrl_d.rb_val   = i_rb_val;
		ctrl_d.imm      = {{(31 - cpu_pkg::IMM_MSB){i_instr[cpu_pkg::IMM_MSB]}},
		                   i_instr[cpu_pkg::IMM_MSB:0]};
		ctrl_d.use_imm  = i_instr[cpu_pkg::USE_IMM_BIT];

		// flag rules are resolved here so execute only looks at two bits
		ctrl_d.update_flags = is_alu && opc == cpu_pkg::ALU_OPC_CMP;
		ctrl_d.update_carry = is_alu && (opc == cpu_pkg::ALU_OPC_ADD ||
		                                 opc == cpu_pkg::ALU_OPC_ADDC ||
		                                 opc == cpu_pkg::ALU_OPC_SUB ||
		                                 opc == cpu_pkg::ALU_OPC_SUBC ||
		                                 opc == cpu_pkg::ALU_OPC_CMP);
	end

	always_ff @(posedge clk) begin
		if (rst)
			o_ctrl <= '0;
		else
			o_ctrl <= ctrl_d;
	end

endmodule

`default_nettype wire

//--- hw/mem_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module mem_writeback (
	input  wire                   clk,
	input  wire                   rst,
	input  cpu_pkg::exec_result_t i_result,
	output logic                  o_rf_wr_en,
	output logic [3:0]            o_rf_wr_idx,
	output logic [31:0]           o_rf_wr_val,
	output cpu_pkg::retire_t      o_retire
);

	logic [31:0]                  dmem [cpu_pkg::DMEM_WORDS];
	logic [cpu_pkg::DMEM_AW-1:0]  word_idx;
	logic [31:0]                  load_val;
	logic [31:0]                  wr_val;
	cpu_pkg::retire_t             retire_d;

	assign word_idx = i_result.addr[2 +: cpu_pkg::DMEM_AW]; // upper address bits alias
	assign load_val = dmem[word_idx];
	assign wr_val   = i_result.mem_load ? load_val : i_result.value;

	// register write lands on the same edge as the retire record
	assign o_rf_wr_en  = i_result.valid && i_result.write_rd;
	assign o_rf_wr_idx = i_result.rd;
	assign o_rf_wr_val = wr_val;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < cpu_pkg::DMEM_WORDS; i++)
				dmem[i] <= 32'b0;
		end else if (i_result.mem_store) begin
			dmem[word_idx] <= i_result.store_data;
		end
	end

	always_comb begin
		retire_d.valid     = i_result.valid;
		retire_d.write_rd  = i_result.write_rd;
		retire_d.rd        = i_result.rd;
		retire_d.data      = wr_val;
		retire_d.is_branch = i_result.branch;
		retire_d.taken     = i_result.branch_taken;
	end

	always_ff @(posedge clk) begin
		if (rst)
			o_retire <= '0;
		else
			o_retire <= retire_d;
	end

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  wire         clk,
	input  wire         rst,
	input  wire  [3:0]  i_ra_idx,
	input  wire  [3:0]  i_rb_idx,
	output logic [31:0] o_ra_val,
	output logic [31:0] o_rb_val,
	input  wire         i_wr_en,
	input  wire  [3:0]  i_wr_idx,
	input  wire  [31:0] i_wr_val
);

	logic [31:0] regs [cpu_pkg::NUM_REGS];

	// no write-through, a read in the write cycle sees the old value
	assign o_ra_val = regs[i_ra_idx];
	assign o_rb_val = regs[i_rb_idx];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < cpu_pkg::NUM_REGS; i++)
				regs[i] <= 32'b0;
		end else if (i_wr_en) begin
			regs[i_wr_idx] <= i_wr_val;
		end
	end

endmodule

`default_nettype wire

//--- sim.f
hw/cpu_pkg.sv
hw/reg_file.sv
hw/instr_decode.sv
hw/exec_stage.sv
hw/mem_writeback.sv
hw/cpu_core.sv
verification/tb_cpu_core.sv

//--- verification/tb_cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core;

	localparam int CLK_PERIOD = 20;
	localparam int N_SEED     = 16;
	localparam int N_ALU      = 200;
	localparam int N_BR       = 60;
	localparam int N_MEM      = 40;
	localparam int N_CR       = 12;
	localparam int N_MIX      = 300;
	localparam int MAX_GAP    = 3;
	localparam int N_INSTR    = 2 + N_SEED + N_ALU + 2 * N_BR + N_MEM + 4 * N_CR + N_MIX;
	// worst case gaps in the mixed stream plus drain and idle time around each of six tests
	localparam int WATCHDOG_CYCLES = N_INSTR + N_MIX * MAX_GAP + 6 * 20 + 40;

	logic             clk = 1'b0;
	logic             rst = 1'b1;
	logic             i_instr_valid = 1'b0;
	logic [31:0]      i_instr = 32'b0;
	cpu_pkg::retire_t o_retire;

	integer seed = 32'hd932;

	// architectural model of the core
	logic [31:0] m_regs [16];
	logic [31:0] m_mem [cpu_pkg::DMEM_WORDS];
	logic [31:0] m_vbar;
	logic        m_z;
	logic        m_c;
	logic        m_n;
	logic        m_o;

	cpu_pkg::retire_t exp_q [$];
	cpu_pkg::retire_t want;
	int recent [3]; // destinations of the last three issued instructions where 16 means none
	int issued;
	int checked;
	int retired;
	int errors;
	int tests_passed;
	int tests_failed;

	cpu_core UUT (
		.clk           (clk),
		.rst           (rst),
		.i_instr_valid (i_instr_valid),
		.i_instr       (i_instr),
		.o_retire      (o_retire)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [11:0] rand_imm();
		logic [31:0] r;
		r = $random(seed);
		return r[11:0];
	endfunction

	function automatic int pick_src();
		int idx;
		idx = rand_below(16);
		while (idx == recent[0] || idx == recent[1] || idx == recent[2])
			idx = rand_below(16);
		return idx;
	endfunction

	function automatic logic [31:0] enc(input logic [1:0] cls, input int opc, input int rd,
	                                    input int ra, input int rb, input int use_imm,
	                                    input logic [11:0] imm);
		logic [31:0] w;
		w = 32'b0;
		w[cpu_pkg::CLASS_LSB +: 2] = cls;
		w[cpu_pkg::OPC_LSB +: 5]   = opc[4:0];
		w[cpu_pkg::RD_LSB +: 4]    = rd[3:0];
		w[cpu_pkg::RA_LSB +: 4]    = ra[3:0];
		w[cpu_pkg::RB_LSB +: 4]    = rb[3:0];
		w[cpu_pkg::USE_IMM_BIT]    = use_imm != 0;
		w[11:0]                    = imm;
		return w;
	endfunction

	function automatic logic branch_cond(input logic [3:0] cc);
		logic lt_signed;
		lt_signed = m_n ^ m_o; // signed less-than after a compare
		case (cc)
		cpu_pkg::BRANCH_CC_NE:   return !m_z;
		cpu_pkg::BRANCH_CC_EQ:   return m_z;
		cpu_pkg::BRANCH_CC_GT:   return m_c & !m_z;
		cpu_pkg::BRANCH_CC_LT:   return !m_c;
		cpu_pkg::BRANCH_CC_GTS:  return !m_z & !lt_signed;
		cpu_pkg::BRANCH_CC_LTS:  return lt_signed;
		cpu_pkg::BRANCH_CC_B:    return 1'b1;
		cpu_pkg::BRANCH_CC_GTE:  return m_c;
		cpu_pkg::BRANCH_CC_GTES: return !lt_signed;
		cpu_pkg::BRANCH_CC_LTE:  return !m_c | m_z;
		cpu_pkg::BRANCH_CC_LTES: return lt_signed | m_z;
		default:                 return 1'b0;
		endcase
	endfunction

	// executes one instruction on the model and returns the record it should retire
	function automatic cpu_pkg::retire_t model_exec(input logic [31:0] instr);
		logic [1:0]  cls;
		logic [4:0]  opc;
		logic [3:0]  rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] r;
		logic [31:0] addr;
		logic [32:0] wide;
		logic [2:0]  sel;
		cpu_pkg::retire_t e;
		cls  = instr[cpu_pkg::CLASS_LSB +: 2];
		opc  = instr[cpu_pkg::OPC_LSB +: 5];
		rd   = instr[cpu_pkg::RD_LSB +: 4];
		a    = m_regs[instr[cpu_pkg::RA_LSB +: 4]];
		imm  = {{20{instr[11]}}, instr[11:0]};
		b    = instr[cpu_pkg::USE_IMM_BIT] ? imm : m_regs[instr[cpu_pkg::RB_LSB +: 4]];
		addr = a + imm;
		sel  = imm[2:0];
		e    = '0;
		e.valid = 1'b1;
		e.rd    = rd;
		case (cls)
		cpu_pkg::CLASS_ALU: begin
			r = a;
			case (opc)
			cpu_pkg::ALU_OPC_ADD: begin
				wide = {1'b0, a} + {1'b0, b};
				m_c  = wide[32];
			end
			cpu_pkg::ALU_OPC_ADDC: begin
				wide = {1'b0, a} + {1'b0, b} + {32'b0, m_c};
				m_c  = wide[32];
			end
			cpu_pkg::ALU_OPC_SUB: begin
				wide = {1'b0, a} - {1'b0, b};
				m_c  = wide[32];
			end
			cpu_pkg::ALU_OPC_SUBC: begin
				wide = {1'b0, a} - {1'b0, b} - {32'b0, m_c};
				m_c  = wide[32];
			end
			cpu_pkg::ALU_OPC_CMP: begin
				wide = {1'b0, a} - {1'b0, b};
				m_z  = a == b;
				m_c  = a >= b;
				m_n  = wide[31];
				m_o  = (a[31] != b[31]) && (wide[31] != a[31]);
			end
			default: wide = 33'b0;
			endcase
			case (opc)
			cpu_pkg::ALU_OPC_ADD, cpu_pkg::ALU_OPC_ADDC, cpu_pkg::ALU_OPC_SUB,
			cpu_pkg::ALU_OPC_SUBC, cpu_pkg::ALU_OPC_CMP: r = wide[31:0];
			cpu_pkg::ALU_OPC_MUL:   r = a * b;
			cpu_pkg::ALU_OPC_LSL:   r = a << b[4:0];
			cpu_pkg::ALU_OPC_LSR:   r = a >> b[4:0];
			cpu_pkg::ALU_OPC_AND:   r = a & b;
			cpu_pkg::ALU_OPC_XOR:   r = a ^ b;
			cpu_pkg::ALU_OPC_BIC:   r[b[4:0]] = 1'b0;
			cpu_pkg::ALU_OPC_BST:   r[b[4:0]] = 1'b1;
			cpu_pkg::ALU_OPC_OR:    r = a | b;
			cpu_pkg::ALU_OPC_COPYB: r = b;
			cpu_pkg::ALU_OPC_MOVHI: r = {a[31:16], a[15:0] | b[15:0]};
			cpu_pkg::ALU_OPC_ASR:   r = (a >> b[4:0]) | (a[31] ? ~(32'hffffffff >> b[4:0]) : 32'b0);
			default:                r = 32'b0;
			endcase
			e.write_rd = opc != cpu_pkg::ALU_OPC_CMP;
			e.data     = r;
		end
		cpu_pkg::CLASS_MEM: begin
			if (opc == cpu_pkg::MEM_OPC_LOAD) begin
				e.write_rd = 1'b1;
				e.data     = m_mem[addr[7:2]];
			end else if (opc == cpu_pkg::MEM_OPC_STORE) begin
				e.data = m_regs[instr[cpu_pkg::RB_LSB +: 4]];
				m_mem[addr[7:2]] = e.data;
			end
		end
		cpu_pkg::CLASS_BRANCH: begin
			e.is_branch = 1'b1;
			e.data      = addr;
			e.taken     = branch_cond(opc[3:0]);
		end
		default: begin
			if (opc == cpu_pkg::CR_OPC_GCR) begin
				e.write_rd = 1'b1;
				if (sel == 3'd0)
					e.data = m_vbar;
				else if (sel == 3'd1)
					e.data = {28'b0, m_n, m_o, m_c, m_z};
			end else if (opc == cpu_pkg::CR_OPC_SCR) begin
				e.data = a;
				if (sel == 3'd0)
					m_vbar = {a[31:6], 6'b0};
				else if (sel == 3'd1)
					{m_n, m_o, m_c, m_z} = a[3:0];
			end
		end
		endcase
		if (e.write_rd)
			m_regs[rd] = e.data;
		return e;
	endfunction

	task automatic issue(input logic [31:0] instr);
		cpu_pkg::retire_t e;
		@(posedge clk);
		i_instr_valid <= 1'b1;
		i_instr       <= instr;
		e = model_exec(instr);
		exp_q.push_back(e);
		recent[2] = recent[1];
		recent[1] = recent[0];
		recent[0] = e.write_rd ? int'(e.rd) : 16;
		issued++;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			i_instr_valid <= 1'b0;
		end
	endtask

	task automatic drain();
		idle(1);
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (3) @(negedge clk); // a stray retire would show up here
		recent = '{16, 16, 16};
	endtask

	task automatic end_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			tests_passed++;
			$display("test %-16s passed at %0t", name, $time);
		end else begin
			tests_failed++;
			$display("test %-16s failed with %0d errors", name, errors - errs_before);
		end
	endtask

	task automatic report_field(input string field, input logic [31:0] got,
	                            input logic [31:0] exp);
		$display("Fail at %0t: retire %0d %s is %h, expected %h", $time, checked, field, got, exp);
		errors++;
	endtask

	// retire records are stable at the falling edge
	always @(negedge clk) begin
		if (!rst && o_retire.valid) begin
			retired++;
			if (exp_q.size() == 0) begin
				$display("unexpected retire at %0t with no instruction outstanding", $time);
				errors++;
			end else begin
				want = exp_q.pop_front();
				if (o_retire.write_rd !== want.write_rd)
					report_field("write_rd", 32'(o_retire.write_rd), 32'(want.write_rd));
				if (o_retire.rd !== want.rd)
					report_field("rd", 32'(o_retire.rd), 32'(want.rd));
				if (o_retire.data !== want.data)
					report_field("data", o_retire.data, want.data);
				if (o_retire.is_branch !== want.is_branch)
					report_field("is_branch", 32'(o_retire.is_branch), 32'(want.is_branch));
				if (o_retire.taken !== want.taken)
					report_field("taken", 32'(o_retire.taken), 32'(want.taken));
				checked++;
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: retire stream stalled, %0d of %0d instructions retired", checked, issued);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		int          errs;
		int          ra;
		int          rb;
		int          sel;
		int          opc;
		logic [1:0]  cls;
		logic [11:0] imm;
		int          st_base [$];
		logic [11:0] st_imm [$];

		for (int i = 0; i < 16; i++)
			m_regs[i] = 32'b0;
		for (int i = 0; i < cpu_pkg::DMEM_WORDS; i++)
			m_mem[i] = 32'b0;
		m_vbar = 32'b0;
		{m_n, m_o, m_c, m_z} = 4'b0;
		recent = '{16, 16, 16};
		issued = 0;
		checked = 0;
		retired = 0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;

		repeat (4) @(posedge clk);
		rst <= 1'b0;

		errs = errors;
		repeat (10) begin
			@(negedge clk);
			if (o_retire.valid) begin
				$display("Fail at %0t: retire valid high while nothing was issued", $time);
				errors++;
			end
		end
		issue(enc(cpu_pkg::CLASS_CR, cpu_pkg::CR_OPC_GCR, 1, 0, 0, 0, 12'd0));
		issue(enc(cpu_pkg::CLASS_CR, cpu_pkg::CR_OPC_GCR, 2, 0, 0, 0, 12'd1));
		drain();
		end_test("reset state", errs);

		errs = errors;
		// load every register with a sign-extended constant first
		for (int i = 0; i < N_SEED; i++)
			issue(enc(cpu_pkg::CLASS_ALU, cpu_pkg::ALU_OPC_COPYB, i, 0, 0, 1, rand_imm()));
		for (int k = 0; k < N_ALU; k++) begin
			if (rand_below(4) == 0)
				opc = rand_below(2) ? cpu_pkg::ALU_OPC_ADDC : cpu_pkg::ALU_OPC_SUBC;
			else
				opc = rand_below(16);
			ra = pick_src();
			rb = pick_src();
			issue(enc(cpu_pkg::CLASS_ALU, opc, rand_below(16), ra, rb, rand_below(2), rand_imm()));
		end
		drain();
		end_test("alu operations", errs);

		errs = errors;
		for (int k = 0; k < N_BR; k++) begin
			ra = pick_src();
			if (rand_below(3) == 0) begin
				issue(enc(cpu_pkg::CLASS_CR, cpu_pkg::CR_OPC_SCR, rand_below(16), ra, 0, 0, 12'd1));
			end else begin
				rb = rand_below(4) == 0 ? ra : pick_src();
				issue(enc(cpu_pkg::CLASS_ALU, cpu_pkg::ALU_OPC_CMP, rand_below(16), ra, rb,
				          rand_below(4) == 0, rand_imm()));
			end
			ra = pick_src();
			issue(enc(cpu_pkg::CLASS_BRANCH, rand_below(32), rand_below(16), ra, 0, 0, rand_imm()));
		end
		drain();
		end_test("compare/branch", errs);

		errs = errors;
		// bases come from r0..r7 and loads only write r8..r15
		for (int k = 0; k < N_MEM; k++) begin
			if (k < 12 || rand_below(2) == 0) begin
				ra  = rand_below(8);
				imm = 12'(rand_below(64) * 4);
				rb  = pick_src();
				issue(enc(cpu_pkg::CLASS_MEM, cpu_pkg::MEM_OPC_STORE, rand_below(16), ra, rb, 0, imm));
				st_base.push_back(ra);
				st_imm.push_back(imm);
			end else begin
				sel = rand_below(st_base.size());
				ra  = rand_below(4) != 0 ? st_base[sel] : rand_below(8);
				imm = rand_below(4) != 0 ? st_imm[sel] : 12'(rand_below(64) * 4);
				issue(enc(cpu_pkg::CLASS_MEM, cpu_pkg::MEM_OPC_LOAD, 8 + rand_below(8), ra, 0, 0, imm));
			end
		end
		drain();
		end_test("memory", errs);

		errs = errors;
		for (int k = 0; k < N_CR; k++) begin
			imm = rand_imm();
			imm[2:0] = 3'd0;
			issue(enc(cpu_pkg::CLASS_CR, cpu_pkg::CR_OPC_SCR, 0, pick_src(), 0, 0, imm));
			issue(enc(cpu_pkg::CLASS_CR, cpu_pkg::CR_OPC_GCR, rand_below(16), 0, 0, 0, imm));
			sel = 2 + rand_below(6);
			imm[2:0] = 3'(sel);
			issue(enc(cpu_pkg::CLASS_CR, cpu_pkg::CR_OPC_SCR, 0, pick_src(), 0, 0, imm));
			issue(enc(cpu_pkg::CLASS_CR, cpu_pkg::CR_OPC_GCR, rand_below(16), 0, 0, 0, imm));
		end
		drain();
		end_test("control regs", errs);

		errs = errors;
		for (int k = 0; k < N_MIX; k++) begin
			cls = 2'(rand_below(4));
			if (cls == cpu_pkg::CLASS_MEM)
				opc = rand_below(2) ? cpu_pkg::MEM_OPC_LOAD : cpu_pkg::MEM_OPC_STORE;
			else if (cls == cpu_pkg::CLASS_CR)
				opc = rand_below(2) ? cpu_pkg::CR_OPC_GCR : cpu_pkg::CR_OPC_SCR;
			else
				opc = rand_below(32);
			ra = pick_src();
			rb = pick_src();
			issue(enc(cls, opc, rand_below(16), ra, rb, rand_below(2), rand_imm()));
			if (rand_below(4) == 0)
				idle(rand_below(MAX_GAP + 1));
		end
		drain();
		if (retired != issued) begin
			$display("retire count %0d does not match %0d issued instructions", retired, issued);
			errors++;
		end
		end_test("mixed stream", errs);

		$display("tests passed %0d failed %0d, %0d of %0d instructions retired, %0d errors",
		         tests_passed, tests_failed, checked, issued, errors);
		if (errors == 0 && tests_failed == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire
